//--- lsu_align.sv
module lsu_align (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     ready,
    input  mem_pkg::mem_op_e         op,
    input  logic [mem_pkg::xlen-1:0] addr,
    input  logic [mem_pkg::xlen-1:0] wdata,
    output logic [mem_pkg::xlen-1:0] rdata,
    output logic                     rvalid,
    mem_req_if.requester             d_bus
);
    import mem_pkg::*;

    logic            is_store;
    logic [1:0]      byte_off;
    logic [xlen-1:0] st_data;
    logic [xlen-1:0] st_mask;
    mem_op_e         ld_op_q;     // operation of the outstanding load
    logic [1:0]      ld_off_q;    // its byte offset in the word
    logic [xlen-1:0] ld_shifted;

    assign is_store = op[3];
    assign byte_off = addr[1:0];

    // store side: replicate the lane across the word and mask the addressed bytes
    always_comb begin
        st_data = wdata;
        st_mask = '0;
        case (op)
            op_sb: begin
                st_data = {4{wdata[7:0]}};
                st_mask = 32'h0000_00ff << {byte_off, 3'b000};
            end
            op_sh: begin
                st_data = {2{wdata[15:0]}};
                st_mask = 32'h0000_ffff << {byte_off[1], 4'b0000};
            end
            op_sw: begin
                st_mask = '1;
            end
            default: begin
                st_mask = '0;  // loads write nothing
            end
        endcase
    end

    assign d_bus.cmd_start = start;
    assign d_bus.cmd_write = is_store;
    assign d_bus.addr      = {addr[xlen-1:2], 2'b00};
    assign d_bus.wdata     = st_data;
    assign d_bus.wmask     = st_mask;

    assign ready = d_bus.cmd_ready;

    // remember how to unpack the load once its data comes back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_op_q  <= op_lw;
            ld_off_q <= 2'b00;
        end else if (start && d_bus.cmd_ready && !is_store) begin
            ld_op_q  <= op;
            ld_off_q <= byte_off;
        end
    end

    // load side: bring the addressed lane down to bit 0, then extend
    assign ld_shifted = d_bus.rdata >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_op_q)
            op_lb:   rdata = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
            op_lbu:  rdata = {24'h0, ld_shifted[7:0]};
            op_lh:   rdata = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
            op_lhu:  rdata = {16'h0, ld_shifted[15:0]};
            default: rdata = d_bus.rdata;  // full word
        endcase
    end

    assign rvalid = d_bus.rdata_valid;

endmodule

//--- mem_arbiter.sv
module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_start,
    output logic                     fetch_ready,
    input  logic [mem_pkg::xlen-1:0] fetch_addr,
    output logic [mem_pkg::xlen-1:0] fetch_inst,
    output logic                     fetch_valid,
    mem_req_if.responder             d_bus,
    mem_req_if.requester             m_bus
);
    import mem_pkg::*;

    arb_state_e      state_q;
    logic            cmd_is_fetch_q;  // current command belongs to fetch
    logic            d_pending_q;     // data command held behind a fetch
    logic [xlen-1:0] fetch_addr_q;
    logic            d_write_q;
    logic [xlen-1:0] d_addr_q;
    logic [xlen-1:0] d_wdata_q;
    logic [xlen-1:0] d_wmask_q;
    logic            idle;
    logic            rsp_done;

    assign idle     = (state_q == st_wait_cmd);
    assign rsp_done = (state_q == st_wait_read) && m_bus.rdata_valid;

    // only take new work when nothing is in progress
    assign fetch_ready     = idle;
    assign d_bus.cmd_ready = idle;

    // steer the memory response to its owner
    assign fetch_inst        = m_bus.rdata;
    assign fetch_valid       = rsp_done && cmd_is_fetch_q;
    assign d_bus.rdata       = m_bus.rdata;
    assign d_bus.rdata_valid = rsp_done && !cmd_is_fetch_q;

    always_comb begin
        m_bus.cmd_start = 1'b0;
        m_bus.cmd_write = 1'b0;
        m_bus.addr      = d_addr_q;
        m_bus.wdata     = d_wdata_q;
        m_bus.wmask     = d_wmask_q;
        case (state_q)
            st_wait_cmd: begin
                // pass straight through, fetch wins a tie
                m_bus.cmd_start = m_bus.cmd_ready && (fetch_start || d_bus.cmd_start);
                m_bus.cmd_write = !fetch_start && d_bus.cmd_write;
                m_bus.addr      = fetch_start ? fetch_addr : d_bus.addr;
                m_bus.wdata     = d_bus.wdata;
                m_bus.wmask     = d_bus.wmask;
            end
            st_wait_ready: begin
                m_bus.cmd_start = 1'b1;
                m_bus.cmd_write = !cmd_is_fetch_q && d_write_q;
                m_bus.addr      = cmd_is_fetch_q ? fetch_addr_q : d_addr_q;
            end
            st_wait_read: begin
                // chain the held data command onto the fetch response
                m_bus.cmd_start = rsp_done && cmd_is_fetch_q && d_pending_q;
                m_bus.cmd_write = d_write_q;
            end
            default: begin
                m_bus.cmd_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= st_wait_cmd;
            cmd_is_fetch_q <= 1'b0;
            d_pending_q    <= 1'b0;
        end else begin
            case (state_q)
                st_wait_cmd: begin
                    if (fetch_start) begin
                        cmd_is_fetch_q <= 1'b1;
                        d_pending_q    <= d_bus.cmd_start;
                        state_q        <= m_bus.cmd_ready ? st_wait_read : st_wait_ready;
                    end else if (d_bus.cmd_start) begin
                        cmd_is_fetch_q <= 1'b0;
                        d_pending_q    <= 1'b0;
                        if (!m_bus.cmd_ready) begin
                            state_q <= st_wait_ready;
                        end else if (!d_bus.cmd_write) begin
                            state_q <= st_wait_read;
                        end
                    end
                end
                st_wait_ready: begin
                    if (m_bus.cmd_ready) begin
                        if (cmd_is_fetch_q || !d_write_q) begin
                            state_q <= st_wait_read;
                        end else begin
                            state_q <= st_wait_cmd;  // write done on acceptance
                        end
                    end
                end
                st_wait_read: begin
                    if (m_bus.rdata_valid) begin
                        if (cmd_is_fetch_q && d_pending_q) begin
                            cmd_is_fetch_q <= 1'b0;
                            d_pending_q    <= 1'b0;
                            if (!m_bus.cmd_ready) begin
                                state_q <= st_wait_ready;
                            end else if (d_write_q) begin
                                state_q <= st_wait_cmd;
                            end else begin
                                state_q <= st_wait_read;  // held load now in flight
                            end
                        end else begin
                            state_q <= st_wait_cmd;
                        end
                    end
                end
                default: state_q <= st_wait_cmd;
            endcase
        end
    end

    // capture both requests at acceptance
    always_ff @(posedge clk) begin
        if (idle && (fetch_start || d_bus.cmd_start)) begin
            fetch_addr_q <= fetch_addr;
            d_write_q    <= d_bus.cmd_write;
            d_addr_q     <= d_bus.addr;
            d_wdata_q    <= d_bus.wdata;
            d_wmask_q    <= d_bus.wmask;
        end
    end

endmodule

//--- mem_model.sv
module mem_model (
    input logic          clk,
    input logic          rst_n,
    mem_req_if.responder bus
);
    import mem_pkg::*;

    logic [xlen-1:0]             mem_array [mem_words];
    logic [mem_read_latency-1:0] rd_valid_q;                      // read pipeline valids
    logic [mem_idx_w-1:0]        rd_idx_q [mem_read_latency-1];   // word index per stage
    logic [xlen-1:0]             rd_data_q;
    logic [mem_idx_w-1:0]        cmd_idx;
    logic                        rd_accept;
    logic                        wr_accept;

    assign cmd_idx   = bus.addr[mem_idx_w+1:2];
    assign rd_accept = bus.cmd_start && bus.cmd_ready && !bus.cmd_write;
    assign wr_accept = bus.cmd_start && bus.cmd_ready && bus.cmd_write;

    // busy while a read sits in any stage before the last
    assign bus.cmd_ready   = ~|rd_valid_q[mem_read_latency-2:0];
    assign bus.rdata_valid = rd_valid_q[mem_read_latency-1];
    assign bus.rdata       = rd_data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q <= {rd_valid_q[mem_read_latency-2:0], rd_accept};
        end
    end

    // index pipeline and the array read into the last stage
    always_ff @(posedge clk) begin
        rd_idx_q[0] <= cmd_idx;
        for (int i = 1; i < mem_read_latency - 1; i++) begin
            rd_idx_q[i] <= rd_idx_q[i-1];
        end
        if (rd_valid_q[mem_read_latency-2]) begin
            rd_data_q <= mem_array[rd_idx_q[mem_read_latency-2]];
        end
    end

    // bit-masked write, old bits kept where wmask is 0
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_array[cmd_idx] <= (mem_array[cmd_idx] & ~bus.wmask) | (bus.wdata & bus.wmask);
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    localparam int xlen = 32;             // data and address width
    localparam int mem_words = 1024;      // memory depth in words
    localparam int mem_idx_w = $clog2(mem_words);
    localparam int mem_read_latency = 2;  // accept to rdata_valid, in cycles

    // load/store opcodes, low bits follow the rv32 funct3 size code
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,  // bit 3 marks a store
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    // arbiter sequencing states
    typedef enum logic [1:0] {
        st_wait_cmd   = 2'd0,  // idle, both requesters may start
        st_wait_ready = 2'd1,  // command held until memory is ready
        st_wait_read  = 2'd2   // read in flight
    } arb_state_e;

endpackage

//--- mem_req_if.sv
interface mem_req_if;
    import mem_pkg::*;

    logic            cmd_start;    // command offered
    logic            cmd_write;    // 1 = write, no response
    logic [xlen-1:0] addr;         // word aligned
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] wmask;        // per-bit write enable
    logic            cmd_ready;    // responder can take a command
    logic [xlen-1:0] rdata;
    logic            rdata_valid;  // single-cycle read response

    modport requester (
        output cmd_start,
        output cmd_write,
        output addr,
        output wdata,
        output wmask,
        input  cmd_ready,
        input  rdata,
        input  rdata_valid
    );

    modport responder (
        input  cmd_start,
        input  cmd_write,
        input  addr,
        input  wdata,
        input  wmask,
        output cmd_ready,
        output rdata,
        output rdata_valid
    );

endinterface

//--- mem_subsys_tests.txt
# name kind(store load fetch both busy) op addr data expected, all numbers in hex
# store: expected is the whole word after it; both/busy: data is the fetch address
sw_100     store  sw   00000100  12345678  12345678
lw_100     load   lw   00000100  00000000  12345678
sw_104     store  sw   00000104  cafef00d  cafef00d
lw_104     load   lw   00000104  00000000  cafef00d
sw_108     store  sw   00000108  00000000  00000000
sb_108     store  sb   00000108  000000a1  000000a1
sb_109     store  sb   00000109  000000b2  0000b2a1
sb_10a     store  sb   0000010a  000000c3  00c3b2a1
sb_10b     store  sb   0000010b  000000d4  d4c3b2a1
lw_108     load   lw   00000108  00000000  d4c3b2a1
sw_10c     store  sw   0000010c  11111111  11111111
sh_10c     store  sh   0000010c  0000beef  1111beef
sh_10e     store  sh   0000010e  00008001  8001beef
lw_10c     load   lw   0000010c  00000000  8001beef
sb_10d     store  sb   0000010d  123456ff  8001ffef
lw_10c_b   load   lw   0000010c  00000000  8001ffef
lb_101     load   lb   00000101  00000000  00000056
lh_102     load   lh   00000102  00000000  00001234
lb_108     load   lb   00000108  00000000  ffffffa1
lb_109     load   lb   00000109  00000000  ffffffb2
lbu_10a    load   lbu  0000010a  00000000  000000c3
lbu_10b    load   lbu  0000010b  00000000  000000d4
lh_108     load   lh   00000108  00000000  ffffb2a1
lhu_10a    load   lhu  0000010a  00000000  0000d4c3
lh_10e     load   lh   0000010e  00000000  ffff8001
lhu_10c    load   lhu  0000010c  00000000  0000ffef
lb_10d     load   lb   0000010d  00000000  ffffffff
fetch_104  fetch  -    00000104  00000000  cafef00d
fetch_100  fetch  -    00000100  00000000  12345678
sw_110     store  sw   00000110  deadbeef  deadbeef
sh_112     store  sh   00000112  00007e7e  7e7ebeef
fetch_110  fetch  -    00000110  00000000  7e7ebeef
lb_113     load   lb   00000113  00000000  0000007e
lhu_110    load   lhu  00000110  00000000  0000beef
both_a     both   lw   00000108  00000104  d4c3b2a1
both_b     both   lbu  0000010f  00000100  00000080
both_c     both   lh   0000010c  00000108  ffffffef
busy_a     busy   lw   00000100  0000010c  12345678
busy_b     busy   lhu  0000010a  00000110  0000d4c3
sw_100_b   store  sw   00000100  0badcafe  0badcafe
lw_100_b   load   lw   00000100  00000000  0badcafe
fetch_100b fetch  -    00000100  00000000  0badcafe

//--- mem_subsys_top.sv
module mem_subsys_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_start,
    output logic                     fetch_ready,
    input  logic [mem_pkg::xlen-1:0] fetch_addr,
    output logic [mem_pkg::xlen-1:0] fetch_inst,
    output logic                     fetch_valid,
    input  logic                     ls_start,
    output logic                     ls_ready,
    input  mem_pkg::mem_op_e         ls_op,
    input  logic [mem_pkg::xlen-1:0] ls_addr,
    input  logic [mem_pkg::xlen-1:0] ls_wdata,
    output logic [mem_pkg::xlen-1:0] ls_rdata,
    output logic                     ls_rvalid
);

    mem_req_if d_bus ();  // aligner to arbiter
    mem_req_if m_bus ();  // arbiter to memory

    lsu_align i_lsu_align (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (ls_start),
        .ready  (ls_ready),
        .op     (ls_op),
        .addr   (ls_addr),
        .wdata  (ls_wdata),
        .rdata  (ls_rdata),
        .rvalid (ls_rvalid),
        .d_bus  (d_bus)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .fetch_inst  (fetch_inst),
        .fetch_valid (fetch_valid),
        .d_bus       (d_bus),
        .m_bus       (m_bus)
    );

    mem_model i_mem_model (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (m_bus)
    );

endmodule

//--- tb.f
mem_pkg.sv
mem_req_if.sv
lsu_align.sv
mem_arbiter.sv
mem_model.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- tb_mem_subsys.sv
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int          fill_words = 8;
    localparam logic [31:0] fill_base  = 32'h0000_0300;

    logic            clk;
    logic            rst_n;
    logic            fetch_start;
    logic            fetch_ready;
    logic [xlen-1:0] fetch_addr;
    logic [xlen-1:0] fetch_inst;
    logic            fetch_valid;
    logic            ls_start;
    logic            ls_ready;
    mem_op_e         ls_op;
    logic [xlen-1:0] ls_addr;
    logic [xlen-1:0] ls_wdata;
    logic [xlen-1:0] ls_rdata;
    logic            ls_rvalid;

    logic [xlen-1:0] shadow [mem_words];    // reference copy of the memory
    logic [31:0]     rng_state = 32'ha6b2_923a;
    int              cycle_cnt = 0;
    int              fetch_rsp_cnt = 0;      // responses seen on the ports
    int              ls_rsp_cnt = 0;
    int              exp_fetch_rsp = 0;      // responses the tests asked for
    int              exp_ls_rsp = 0;
    int              watchdog_cycles = 0;

    string           t_name [$];
    string           t_kind [$];
    string           t_op [$];
    logic [31:0]     t_addr [$];
    logic [31:0]     t_data [$];
    logic [31:0]     t_exp [$];

    mem_subsys_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .fetch_inst  (fetch_inst),
        .fetch_valid (fetch_valid),
        .ls_start    (ls_start),
        .ls_ready    (ls_ready),
        .ls_op       (ls_op),
        .ls_addr     (ls_addr),
        .ls_wdata    (ls_wdata),
        .ls_rdata    (ls_rdata),
        .ls_rvalid   (ls_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // count every response pulse, catches lost or doubled ones
    always @(posedge clk) begin
        cycle_cnt++;
        if (rst_n && fetch_valid) fetch_rsp_cnt++;
        if (rst_n && ls_rvalid) ls_rsp_cnt++;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("timeout: the tests did not finish in the expected number of cycles");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic decode_op(input string s, output mem_op_e op);
        op = op_lw;
        case (s)
            "lb":    op = op_lb;
            "lh":    op = op_lh;
            "lw":    op = op_lw;
            "lbu":   op = op_lbu;
            "lhu":   op = op_lhu;
            "sb":    op = op_sb;
            "sh":    op = op_sh;
            "sw":    op = op_sw;
            default: fail_run({"unknown operation in test file: ", s});
        endcase
    endtask

    // byte lanes written one by one, rest of the word kept
    task automatic shadow_store(input mem_op_e op, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] word;
        word = shadow[a[mem_idx_w+1:2]];
        case (op)
            op_sb:   word[a[1:0]*8 +: 8] = d[7:0];
            op_sh:   word[a[1]*16 +: 16] = d[15:0];
            default: word = d;
        endcase
        shadow[a[mem_idx_w+1:2]] = word;
    endtask

    function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] a);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = shadow[a[mem_idx_w+1:2]];
        b = word[a[1:0]*8 +: 8];
        h = word[a[1]*16 +: 16];
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic do_store(input mem_op_e op, input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        ls_start = 1'b1;
        ls_op    = op;
        ls_addr  = a;
        ls_wdata = d;
        while (!ls_ready) @(negedge clk);
        @(negedge clk);
        ls_start = 1'b0;
        shadow_store(op, a, d);
    endtask

    task automatic do_load(input string name, input mem_op_e op, input logic [31:0] a,
                           output logic [31:0] data);
        @(negedge clk);
        ls_start = 1'b1;
        ls_op    = op;
        ls_addr  = a;
        while (!ls_ready) @(negedge clk);
        @(negedge clk);
        ls_start = 1'b0;
        check_value({name, " ready while busy"}, 32'h0, {ls_ready, fetch_ready});
        while (!ls_rvalid) @(negedge clk);
        data = ls_rdata;
        exp_ls_rsp++;
    endtask

    task automatic do_fetch(input string name, input logic [31:0] a, output logic [31:0] inst);
        @(negedge clk);
        fetch_start = 1'b1;
        fetch_addr  = a;
        while (!fetch_ready) @(negedge clk);
        @(negedge clk);
        fetch_start = 1'b0;
        check_value({name, " ready while busy"}, 32'h0, {ls_ready, fetch_ready});
        while (!fetch_valid) @(negedge clk);
        inst = fetch_inst;
        exp_fetch_rsp++;
    endtask

    // fetch and load offered in the same cycle
    task automatic do_both(input mem_op_e op, input logic [31:0] la, input logic [31:0] fa,
                           output logic [31:0] ld, output logic [31:0] inst,
                           output int f_cyc, output int l_cyc);
        @(negedge clk);
        fetch_start = 1'b1;
        fetch_addr  = fa;
        ls_start    = 1'b1;
        ls_op       = op;
        ls_addr     = la;
        while (!(ls_ready && fetch_ready)) @(negedge clk);
        @(negedge clk);
        fetch_start = 1'b0;
        ls_start    = 1'b0;
        f_cyc = -1;
        l_cyc = -1;
        while (f_cyc < 0 || l_cyc < 0) begin
            @(negedge clk);
            if (fetch_valid) begin
                f_cyc = cycle_cnt;
                inst  = fetch_inst;
            end
            if (ls_rvalid) begin
                l_cyc = cycle_cnt;
                ld    = ls_rdata;
            end
        end
        exp_fetch_rsp++;
        exp_ls_rsp++;
    endtask

    // fetch offered while the load is still in flight, must wait for ready
    task automatic do_busy(input string name, input mem_op_e op, input logic [31:0] la,
                           input logic [31:0] fa, output logic [31:0] ld,
                           output logic [31:0] inst);
        logic got_l;
        logic got_f;
        logic drop;
        @(negedge clk);
        ls_start = 1'b1;
        ls_op    = op;
        ls_addr  = la;
        while (!ls_ready) @(negedge clk);
        @(negedge clk);
        ls_start    = 1'b0;
        fetch_start = 1'b1;
        fetch_addr  = fa;
        check_value({name, " ready while busy"}, 32'h0, {ls_ready, fetch_ready});
        got_l = 1'b0;
        got_f = 1'b0;
        while (!(got_l && got_f)) begin
            drop = fetch_start && fetch_ready;  // accepted at the coming edge
            @(negedge clk);
            if (drop) fetch_start = 1'b0;
            if (ls_rvalid) begin
                ld    = ls_rdata;
                got_l = 1'b1;
            end
            if (fetch_valid) begin
                inst  = fetch_inst;
                got_f = 1'b1;
            end
        end
        exp_fetch_rsp++;
        exp_ls_rsp++;
    endtask

    task automatic settle_check(input string name);
        repeat (3) @(negedge clk);
        check_value({name, " fetch responses"}, exp_fetch_rsp, fetch_rsp_cnt);
        check_value({name, " load responses"}, exp_ls_rsp, ls_rsp_cnt);
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        string       opn;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("mem_subsys_tests.txt", "r");
        if (fd == 0) fail_run("cannot open the test file mem_subsys_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2) continue;
            if (line.getc(0) == "#") continue;  // column description
            n = $sscanf(line, "%s %s %s %h %h %h", name, kind, opn, a, d, e);
            if (n != 6) fail_run({"malformed line in test file: ", line});
            t_name.push_back(name);
            t_kind.push_back(kind);
            t_op.push_back(opn);
            t_addr.push_back(a);
            t_data.push_back(d);
            t_exp.push_back(e);
        end
        $fclose(fd);
        if (t_name.size() == 0) fail_run("the test file holds no tests");
    endtask

    // random words stored, read back as loads and one fetch
    task automatic run_fill();
        logic [31:0] got;
        for (int i = 0; i < fill_words; i++) begin
            rng_state = xorshift32(rng_state);
            do_store(op_sw, fill_base + 4 * i, rng_state);
        end
        for (int i = 0; i < fill_words; i++) begin
            do_load($sformatf("fill_%0d", i), op_lw, fill_base + 4 * i, got);
            check_value($sformatf("fill_%0d", i), shadow[(fill_base >> 2) + i], got);
        end
        do_fetch("fill_fetch", fill_base, got);
        check_value("fill_fetch", shadow[fill_base >> 2], got);
        settle_check("fill");
    endtask

    task automatic run_test(input int i);
        mem_op_e     op;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] exp_l;
        logic [31:0] exp_f;
        logic [31:0] got_l;
        logic [31:0] got_f;
        int          f_cyc;
        int          l_cyc;
        name = t_name[i];
        a    = t_addr[i];
        d    = t_data[i];
        op   = op_lw;
        if (t_kind[i] != "fetch") decode_op(t_op[i], op);
        exp_l = expected_load(op, a);
        exp_f = shadow[d[mem_idx_w+1:2]];  // both and busy fetch from the data column
        case (t_kind[i])
            "store": begin
                do_store(op, a, d);
                check_value({name, " file"}, t_exp[i], shadow[a[mem_idx_w+1:2]]);
            end
            "load": begin
                check_value({name, " file"}, t_exp[i], exp_l);
                do_load(name, op, a, got_l);
                check_value(name, exp_l, got_l);
            end
            "fetch": begin
                exp_f = shadow[a[mem_idx_w+1:2]];
                check_value({name, " file"}, t_exp[i], exp_f);
                do_fetch(name, a, got_f);
                check_value(name, exp_f, got_f);
            end
            "both": begin
                check_value({name, " file"}, t_exp[i], exp_l);
                do_both(op, a, d, got_l, got_f, f_cyc, l_cyc);
                check_value({name, " load"}, exp_l, got_l);
                check_value({name, " fetch"}, exp_f, got_f);
                check_value({name, " fetch first"}, 32'h1, 32'(f_cyc <= l_cyc));
            end
            "busy": begin
                check_value({name, " file"}, t_exp[i], exp_l);
                do_busy(name, op, a, d, got_l, got_f);
                check_value({name, " load"}, exp_l, got_l);
                check_value({name, " fetch"}, exp_f, got_f);
            end
            default: fail_run({"unknown test kind ", t_kind[i], " in test ", name});
        endcase
        settle_check(name);
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_start = 1'b0;
        fetch_addr  = '0;
        ls_start    = 1'b0;
        ls_op       = op_lw;
        ls_addr     = '0;
        ls_wdata    = '0;
        load_tests();
        watchdog_cycles = (t_name.size() + 2 * fill_words + 4) * 40;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_fill();
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule
